//--- dv/exec_mem_model.sv
`timescale 1ns/10ps

module exec_mem_model (
    input  logic                 clk,
    input  logic                 rst_n,
    input  exec_pkg::mem_req_t   mem_req,
    output exec_pkg::mem_rsp_t   mem_rsp,
    input  logic [2:0]           delay,
    input  exec_pkg::mem_resp_e  inject
);
    import exec_pkg::*;

    logic       active;
    logic [2:0] count;

    // Fill pattern mixes every address bit
    function automatic logic [31:0] fill_word(input logic [31:0] a);
        return {a[15:0], a[31:16]} ^ (a * 32'h9e37_79b9);
    endfunction

    // Reply after delay wait cycles, never in the first command cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            active            <= 1'b0;
            count             <= 3'd0;
            mem_rsp.resp      <= mem_resp_wait;
            mem_rsp.load_data <= '0;
        end else if (mem_rsp.resp != mem_resp_wait) begin
            // Response lasts one cycle
            mem_rsp.resp <= mem_resp_wait;
            active       <= 1'b0;
        end else if (active) begin
            if (count == 3'd0) begin
                mem_rsp.resp <= inject;
                if (mem_req.cmd == mem_cmd_load) begin
                    mem_rsp.load_data <= fill_word(mem_req.address);
                end else begin
                    mem_rsp.load_data <= '0;
                end
            end else begin
                count <= count - 3'd1;
            end
        end else if (mem_req.cmd != mem_cmd_none) begin
            active <= 1'b1;
            count  <= delay - 3'd1;
        end
    end

endmodule

//--- dv/exec_tb.sv
`timescale 1ns/10ps

module exec_tb;
    import exec_pkg::*;

    logic        clk;
    logic        rst_n;
    fetch_in_t   fetch_in;
    logic        ready;
    redirect_t   redirect;
    exc_t        exc;
    logic [4:0]  rs1_addr;
    logic [4:0]  rs2_addr;
    logic [31:0] rs1_data;
    logic [31:0] rs2_data;
    rd_write_t   rd;
    mem_req_t    mem_req;
    mem_rsp_t    mem_rsp;
    logic [2:0]  mem_delay;
    mem_resp_e   mem_inject;
    logic [31:0] regs [32];
    logic [31:0] seed;
    int          checks;
    int          errors;
    int          err_mark;

    exec_stage uut (
        .clk      (clk),
        .rst_n    (rst_n),
        .fetch_in (fetch_in),
        .ready    (ready),
        .redirect (redirect),
        .exc      (exc),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .rd       (rd),
        .mem_req  (mem_req),
        .mem_rsp  (mem_rsp)
    );

    exec_mem_model mem (
        .clk     (clk),
        .rst_n   (rst_n),
        .mem_req (mem_req),
        .mem_rsp (mem_rsp),
        .delay   (mem_delay),
        .inject  (mem_inject)
    );

    // Register file read ports
    assign rs1_data = regs[rs1_addr];
    assign rs2_data = regs[rs2_addr];

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic logic [4:0] pick_reg();
        logic [31:0] t;
        t = next_rand() % 32'd31;
        return t[4:0] + 5'd1;
    endfunction

    function automatic logic [31:0] sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic is_imm, input logic [31:0] a,
                                            input logic [31:0] b);
        case (f3)
            3'd0: return (alt && !is_imm) ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return {31'd0, $signed(a) < $signed(b)};
            3'd3: return {31'd0, a < b};
            3'd4: return a ^ b;
            3'd5: return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_ref(input logic [2:0] f3, input logic [31:0] a,
                                        input logic [31:0] b);
        case (f3)
            3'd0: return a == b;
            3'd1: return a != b;
            3'd4: return $signed(a) < $signed(b);
            3'd5: return $signed(a) >= $signed(b);
            3'd6: return a < b;
            default: return a >= b;
        endcase
    endfunction

    function automatic logic [31:0] expected_load(input logic [31:0] a);
        return {a[15:0], a[31:16]} ^ (a * 32'h9e37_79b9);
    endfunction

    function automatic logic [31:0] rand_pc();
        logic [31:0] t;
        t = next_rand();
        return {t[31:2], 2'b00};
    endfunction

    task automatic check_true(input logic cond, input string msg);
        checks++;
        assert (cond) else begin
            errors++;
            $display("[FAIL] %0t ns: %s", $time, msg);
        end
    endtask

    task automatic report_test(input string name);
        $display("%s finished with %0d errors", name, errors - err_mark);
        err_mark = errors;
    endtask

    task automatic abort_timeout(input string what);
        $display("Timeout: %s never raised ready", what);
        $display("Done: errors found");
        $finish;
    endtask

    task automatic drive(input logic [31:0] instr, input logic [31:0] pc);
        fetch_in.instr = instr;
        fetch_in.pc    = pc;
        @(negedge clk);
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic run_alu(input int k, input logic is_imm);
        logic [2:0]  f3;
        logic        alt;
        logic [4:0]  s1;
        logic [4:0]  s2;
        logic [4:0]  d;
        logic [31:0] r;
        logic [11:0] imm12;
        logic [31:0] b;
        logic [31:0] instr;
        f3 = (k <= 1) ? 3'd0 : ((k <= 6) ? 3'(k - 1) : 3'(k - 2));
        alt = (k == 1) || (k == 7);
        s1 = pick_reg();
        s2 = pick_reg();
        d = pick_reg();
        regs[s1] = next_rand();
        regs[s2] = next_rand();
        r = next_rand();
        if (is_imm) begin
            imm12 = (f3 == 3'd1 || f3 == 3'd5) ? {1'b0, alt, 5'd0, r[4:0]} : r[11:0];
            b = sext12(imm12);
            instr = {imm12, s1, f3, d, op_imm};
        end else begin
            b = regs[s2];
            instr = {1'b0, alt, 5'd0, s2, s1, f3, d, op};
        end
        drive(instr, rand_pc());
        check_true(ready && rd.write && rd.addr == d, "ALU op did not retire with a write");
        check_true(rd.data == alu_ref(f3, alt, is_imm, regs[s1], b), "ALU result wrong");
        next_cycle();
    endtask

    task automatic run_branch(input logic [2:0] f3);
        logic [4:0]  s1;
        logic [4:0]  s2;
        logic [31:0] r;
        logic [12:0] imm;
        logic [31:0] pc;
        s1 = pick_reg();
        s2 = pick_reg();
        r = next_rand();
        regs[s1] = next_rand();
        regs[s2] = r[0] ? regs[s1] : next_rand();
        imm = {r[12:1], 1'b0};
        pc = rand_pc();
        drive({imm[12], imm[10:5], s2, s1, f3, imm[4:1], imm[11], branch}, pc);
        check_true(ready && !rd.write, "Branch not retired or wrote a register");
        check_true(redirect.taken == branch_ref(f3, regs[s1], regs[s2]), "Branch taken wrong");
        check_true(redirect.target == pc + {{19{imm[12]}}, imm}, "Branch target wrong");
        next_cycle();
    endtask

    task automatic run_mem(input logic is_store, input logic [2:0] f3, input mem_resp_e inj);
        logic [4:0]  s1;
        logic [4:0]  s2;
        logic [4:0]  d;
        logic [31:0] r;
        logic [31:0] addr;
        logic [31:0] cause;
        int          n;
        logic        done;
        s1 = pick_reg();
        s2 = pick_reg();
        d = pick_reg();
        regs[s1] = next_rand();
        regs[s2] = next_rand();
        r = next_rand();
        addr = regs[s1] + sext12(r[11:0]);
        mem_delay = {1'b0, r[13:12]} + 3'd1;
        mem_inject = inj;
        if (is_store) begin
            fetch_in.instr = {r[11:5], s2, s1, f3, r[4:0], store};
        end else begin
            fetch_in.instr = {r[11:0], s1, f3, d, load};
        end
        fetch_in.pc = rand_pc();
        n = 0;
        done = 1'b0;
        while (!done && n < 10) begin
            @(negedge clk);
            n++;
            check_true(mem_req.cmd == (is_store ? mem_cmd_store : mem_cmd_load),
                       "Memory command wrong or dropped");
            check_true(mem_req.address == addr && mem_req.size == f3,
                       "Memory address or size wrong");
            check_true(!is_store || mem_req.store_data == regs[s2], "Memory store data wrong");
            if (ready) begin
                done = 1'b1;
            end else begin
                check_true(!rd.write && !exc.start, "Write or trap before memory response");
                next_cycle();
            end
        end
        if (!done) begin
            abort_timeout("memory access");
        end else begin
            check_true(n > 1, "Memory access finished in its first cycle");
            if (inj == mem_resp_done) begin
                check_true(!exc.start, "Trap on a good memory response");
                if (is_store) begin
                    check_true(!rd.write, "Store wrote a register");
                end else begin
                    check_true(rd.write && rd.addr == d, "Load did not write its register");
                    check_true(rd.data == expected_load(addr), "Load data wrong");
                end
            end else begin
                if (inj == mem_resp_misaligned) begin
                    cause = is_store ? 32'd6 : 32'd4;
                end else begin
                    cause = is_store ? 32'd7 : 32'd5;
                end
                check_true(exc.start && exc.cause == cause, "Memory fault trap or cause wrong");
                check_true(!rd.write, "Register written on memory fault");
            end
            next_cycle();
        end
    endtask

    task automatic run_illegal(input logic [31:0] instr);
        drive(instr, rand_pc());
        check_true(!ready && !exc.start, "Illegal instruction not stalled");
        check_true(!rd.write && mem_req.cmd == mem_cmd_none, "Illegal cycle 1 side effect");
        next_cycle();
        @(negedge clk);
        check_true(ready && exc.start && exc.cause == 32'd2, "Illegal trap missing");
        check_true(!rd.write && mem_req.cmd == mem_cmd_none, "Illegal cycle 2 side effect");
        next_cycle();
    endtask

    initial begin
        logic [31:0] r;
        logic [31:0] pc;
        logic [4:0]  s1;
        logic [4:0]  d;
        seed = 32'hfe73;
        checks = 0;
        errors = 0;
        err_mark = 0;
        rst_n = 1'b0;
        mem_delay = 3'd1;
        mem_inject = mem_resp_done;
        fetch_in.instr = 32'h0000_0013;
        fetch_in.pc = 32'd0;
        for (int i = 0; i < 32; i++) begin
            regs[i] = 32'd0;
        end
        repeat (3) @(posedge clk);
        #2;
        rst_n = 1'b1;
        @(negedge clk);
        check_true(!exc.start && mem_req.cmd == mem_cmd_none, "State after reset wrong");
        next_cycle();

        for (int k = 0; k < 10; k++) begin
            for (int it = 0; it < 4; it++) begin
                run_alu(k, 1'b0);
                if (k != 1) begin
                    run_alu(k, 1'b1);
                end
            end
        end
        report_test("alu");

        for (int it = 0; it < 5; it++) begin
            run_branch(3'd0);
            run_branch(3'd1);
            run_branch(3'd4);
            run_branch(3'd5);
            run_branch(3'd6);
            run_branch(3'd7);
            // JAL then JALR
            r = next_rand();
            d = pick_reg();
            pc = rand_pc();
            drive({r[20], r[10:1], r[11], r[19:12], d, jal}, pc);
            check_true(redirect.taken, "JAL not taken");
            check_true(redirect.target == pc + {{11{r[20]}}, r[20:1], 1'b0}, "JAL target wrong");
            check_true(rd.write && rd.data == pc + 32'd4, "JAL link wrong");
            next_cycle();
            s1 = pick_reg();
            regs[s1] = next_rand();
            drive({r[31:20], s1, 3'b000, d, jalr}, pc);
            check_true(redirect.taken, "JALR not taken");
            check_true(redirect.target == ((regs[s1] + sext12(r[31:20])) & 32'hffff_fffe),
                       "JALR target wrong");
            check_true(rd.write && rd.data == pc + 32'd4, "JALR link wrong");
            next_cycle();
        end
        report_test("branch");

        for (int it = 0; it < 6; it++) begin
            r = next_rand();
            d = pick_reg();
            pc = rand_pc();
            drive({r[31:12], d, lui}, pc);
            check_true(rd.write && rd.data == {r[31:12], 12'd0}, "LUI value wrong");
            next_cycle();
            drive({r[31:12], d, auipc}, pc);
            check_true(rd.write && rd.data == pc + {r[31:12], 12'd0}, "AUIPC value wrong");
            next_cycle();
            // Same instructions aimed at x0
            drive({r[31:12], 5'd0, lui}, pc);
            check_true(ready && !rd.write, "LUI to x0 wrote");
            next_cycle();
            drive({12'd0, d, 3'd0, 5'd0, op_imm}, pc);
            check_true(ready && !rd.write, "ADDI to x0 wrote");
            next_cycle();
            drive({r[31:12], 5'd0, jal}, pc);
            check_true(ready && !rd.write, "JAL to x0 wrote");
            next_cycle();
        end
        report_test("upper and x0");

        for (int it = 0; it < 4; it++) begin
            run_mem(1'b0, 3'd0, mem_resp_done);
            run_mem(1'b0, 3'd2, mem_resp_done);
            run_mem(1'b0, 3'd5, mem_resp_done);
            run_mem(1'b1, 3'd0, mem_resp_done);
            run_mem(1'b1, 3'd1, mem_resp_done);
            run_mem(1'b1, 3'd2, mem_resp_done);
        end
        report_test("load and store");

        for (int it = 0; it < 3; it++) begin
            run_mem(1'b0, 3'd2, mem_resp_misaligned);
            run_mem(1'b0, 3'd1, mem_resp_access_fault);
            run_mem(1'b1, 3'd2, mem_resp_misaligned);
            run_mem(1'b1, 3'd0, mem_resp_access_fault);
        end
        report_test("memory errors");

        run_illegal(32'hffff_ffff);
        run_illegal({12'h004, 5'd3, 3'b001, 5'd4, jalr});
        run_illegal({12'h010, 5'd6, 3'b110, 5'd7, jalr});
        // Bad branch funct3, bad store size and bad funct7
        run_illegal({7'd0, 5'd2, 5'd1, 3'b010, 5'd0, branch});
        run_illegal({7'd0, 5'd2, 5'd1, 3'b011, 5'd0, store});
        run_illegal({7'b0000001, 5'd2, 5'd1, 3'b000, 5'd5, op});
        report_test("illegal");

        $display("Tests done: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- files.f
hdl/exec_pkg.sv
hdl/exec_decoder.sv
hdl/exec_alu.sv
hdl/exec_branch_unit.sv
hdl/exec_mem_ctrl.sv
hdl/exec_stage.sv
dv/exec_mem_model.sv
dv/exec_tb.sv

//--- hdl/exec_alu.sv
`timescale 1ns/10ps

module exec_alu (
    input  logic                      is_imm,
    input  logic [2:0]                funct3,
    input  logic [6:0]                funct7,
    input  logic [exec_pkg::xlen-1:0] rs1,
    input  logic [exec_pkg::xlen-1:0] rs2,
    input  logic [exec_pkg::xlen-1:0] imm,
    output logic [exec_pkg::xlen-1:0] result,
    output logic                      illegal
);
    import exec_pkg::*;

    logic [xlen-1:0] operand_b;
    logic [4:0]      shamt;
    logic            alt;

    assign operand_b = is_imm ? imm : rs2;
    assign shamt     = operand_b[4:0];
    // SUB and SRA select
    assign alt       = funct7[5];

    always_comb begin
        case (funct3)
            3'b000: result = (!is_imm && alt) ? rs1 - operand_b : rs1 + operand_b;
            3'b001: result = rs1 << shamt;
            3'b010: result = {{(xlen-1){1'b0}}, $signed(rs1) < $signed(operand_b)};
            3'b011: result = {{(xlen-1){1'b0}}, rs1 < operand_b};
            3'b100: result = rs1 ^ operand_b;
            3'b101: result = alt ? $unsigned($signed(rs1) >>> shamt) : rs1 >> shamt;
            3'b110: result = rs1 | operand_b;
            default: result = rs1 & operand_b;
        endcase
    end

    // Allowed funct7 values depend on the form
    always_comb begin
        illegal = 1'b0;
        if (is_imm) begin
            if (funct3 == 3'b001) begin
                illegal = (funct7 != 7'b0000000);
            end else if (funct3 == 3'b101) begin
                illegal = (funct7 != 7'b0000000) && (funct7 != 7'b0100000);
            end
        end else begin
            if (funct3 == 3'b000 || funct3 == 3'b101) begin
                illegal = (funct7 != 7'b0000000) && (funct7 != 7'b0100000);
            end else begin
                illegal = (funct7 != 7'b0000000);
            end
        end
    end

endmodule

//--- hdl/exec_branch_unit.sv
`timescale 1ns/10ps

module exec_branch_unit (
    input  exec_pkg::decoded_t        dec,
    input  logic [exec_pkg::xlen-1:0] pc,
    input  logic [exec_pkg::xlen-1:0] rs1,
    input  logic [exec_pkg::xlen-1:0] rs2,
    output exec_pkg::redirect_t       redirect,
    output logic                      illegal
);
    import exec_pkg::*;

    logic            cond;
    logic            bad_funct3;
    logic [xlen-1:0] jalr_sum;

    always_comb begin
        bad_funct3 = 1'b0;
        case (dec.funct3)
            3'b000: cond = (rs1 == rs2);
            3'b001: cond = (rs1 != rs2);
            3'b100: cond = ($signed(rs1) < $signed(rs2));
            3'b101: cond = ($signed(rs1) >= $signed(rs2));
            3'b110: cond = (rs1 < rs2);
            3'b111: cond = (rs1 >= rs2);
            default: begin
                cond       = 1'b0;
                bad_funct3 = 1'b1;
            end
        endcase
    end

    assign jalr_sum = rs1 + dec.imm;
    assign illegal  = (dec.iclass == cls_branch) && bad_funct3;

    always_comb begin
        redirect.taken  = 1'b0;
        redirect.target = pc + dec.imm;
        case (dec.iclass)
            cls_jal: redirect.taken = 1'b1;
            cls_jalr: begin
                redirect.taken  = 1'b1;
                redirect.target = {jalr_sum[xlen-1:1], 1'b0};
            end
            cls_branch: redirect.taken = cond;
            default: redirect.taken = 1'b0;
        endcase
    end

endmodule

//--- hdl/exec_decoder.sv
`timescale 1ns/10ps

module exec_decoder (
    input  logic [exec_pkg::xlen-1:0] instr,
    output exec_pkg::decoded_t        dec
);
    import exec_pkg::*;

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic            sign;
    logic [xlen-1:0] imm_i;
    logic [xlen-1:0] imm_s;
    logic [xlen-1:0] imm_b;
    logic [xlen-1:0] imm_u;
    logic [xlen-1:0] imm_j;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign sign   = instr[31];

    // Immediate formats with the sign taken from bit 31
    assign imm_i = {{20{sign}}, instr[31:20]};
    assign imm_s = {{20{sign}}, instr[31:25], instr[11:7]};
    assign imm_b = {{20{sign}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'h000};
    assign imm_j = {{12{sign}}, instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        dec.funct3 = funct3;
        dec.funct7 = instr[31:25];
        dec.rd     = instr[11:7];
        dec.imm    = imm_i;

        case (opcode)
            op_imm, op: begin
                dec.iclass = cls_alu;
            end
            jal: begin
                dec.iclass = cls_jal;
                dec.imm    = imm_j;
            end
            jalr: begin
                // Only funct3 of zero is defined
                dec.iclass = (funct3 == 3'b000) ? cls_jalr : cls_illegal;
            end
            branch: begin
                dec.iclass = cls_branch;
                dec.imm    = imm_b;
            end
            lui: begin
                dec.iclass = cls_lui;
                dec.imm    = imm_u;
            end
            auipc: begin
                dec.iclass = cls_auipc;
                dec.imm    = imm_u;
            end
            load: begin
                dec.iclass = cls_load;
            end
            store: begin
                // SB, SH and SW only
                dec.iclass = (funct3 > 3'd2) ? cls_illegal : cls_store;
                dec.imm    = imm_s;
            end
            default: begin
                dec.iclass = cls_illegal;
            end
        endcase
    end

endmodule

//--- hdl/exec_mem_ctrl.sv
`timescale 1ns/10ps

module exec_mem_ctrl (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      start_load,
    input  logic                      start_store,
    input  logic [exec_pkg::xlen-1:0] address,
    input  logic [2:0]                size,
    input  logic [exec_pkg::xlen-1:0] store_data,
    output exec_pkg::mem_req_t        mem_req,
    input  exec_pkg::mem_rsp_t        mem_rsp,
    output logic                      busy,
    output exec_pkg::exc_t            fault
);
    import exec_pkg::*;

    logic issued;
    logic responded;
    logic is_error;

    // Memory never answers in the first cycle, so only look once issued
    assign responded = issued && (mem_rsp.resp != mem_resp_wait);
    assign is_error  = responded && (mem_rsp.resp == mem_resp_misaligned ||
                                     mem_rsp.resp == mem_resp_access_fault);

    always_comb begin
        if (start_load) begin
            mem_req.cmd = mem_cmd_load;
        end else if (start_store) begin
            mem_req.cmd = mem_cmd_store;
        end else begin
            mem_req.cmd = mem_cmd_none;
        end
        mem_req.address    = address;
        mem_req.size       = size;
        mem_req.store_data = store_data;
    end

    assign busy = (start_load || start_store) && !responded;

    always_comb begin
        fault.start = is_error;
        if (mem_rsp.resp == mem_resp_misaligned) begin
            fault.cause = start_load ? cause_load_misaligned : cause_store_misaligned;
        end else begin
            fault.cause = start_load ? cause_load_access : cause_store_access;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            issued <= 1'b0;
        end else if (responded) begin
            issued <= 1'b0;
        end else if (start_load || start_store) begin
            issued <= 1'b1;
        end
    end

endmodule

//--- hdl/exec_pkg.sv
package exec_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    // RV32I base opcodes
    localparam logic [6:0] op_imm = 7'b0010011;
    localparam logic [6:0] op     = 7'b0110011;
    localparam logic [6:0] jal    = 7'b1101111;
    localparam logic [6:0] jalr   = 7'b1100111;
    localparam logic [6:0] branch = 7'b1100011;
    localparam logic [6:0] lui    = 7'b0110111;
    localparam logic [6:0] auipc  = 7'b0010111;
    localparam logic [6:0] load   = 7'b0000011;
    localparam logic [6:0] store  = 7'b0100011;

    // Exception cause codes as in mcause
    localparam logic [31:0] cause_illegal          = 32'd2;
    localparam logic [31:0] cause_load_misaligned  = 32'd4;
    localparam logic [31:0] cause_load_access      = 32'd5;
    localparam logic [31:0] cause_store_misaligned = 32'd6;
    localparam logic [31:0] cause_store_access     = 32'd7;

    typedef enum logic [1:0] {
        mem_cmd_none,
        mem_cmd_load,
        mem_cmd_store
    } mem_cmd_e;

    typedef enum logic [1:0] {
        mem_resp_wait,
        mem_resp_done,
        mem_resp_misaligned,
        mem_resp_access_fault
    } mem_resp_e;

    typedef enum logic [3:0] {
        cls_alu,
        cls_jal,
        cls_jalr,
        cls_branch,
        cls_lui,
        cls_auipc,
        cls_load,
        cls_store,
        cls_illegal
    } instr_class_e;

    typedef struct packed {
        logic [xlen-1:0] instr;
        logic [xlen-1:0] pc;
    } fetch_in_t;

    typedef struct packed {
        instr_class_e          iclass;
        logic [2:0]            funct3;
        logic [6:0]            funct7;
        logic [reg_addr_w-1:0] rd;
        logic [xlen-1:0]       imm;
    } decoded_t;

    typedef struct packed {
        logic            taken;
        logic [xlen-1:0] target;
    } redirect_t;

    // Size carries funct3 unchanged
    typedef struct packed {
        mem_cmd_e        cmd;
        logic [xlen-1:0] address;
        logic [2:0]      size;
        logic [xlen-1:0] store_data;
    } mem_req_t;

    typedef struct packed {
        mem_resp_e       resp;
        logic [xlen-1:0] load_data;
    } mem_rsp_t;

    typedef struct packed {
        logic [reg_addr_w-1:0] addr;
        logic [xlen-1:0]       data;
        logic                  write;
    } rd_write_t;

    typedef struct packed {
        logic        start;
        logic [31:0] cause;
    } exc_t;

endpackage

//--- hdl/exec_stage.sv
`timescale 1ns/10ps

module exec_stage (
    input  logic                            clk,
    input  logic                            rst_n,
    input  exec_pkg::fetch_in_t             fetch_in,
    output logic                            ready,
    output exec_pkg::redirect_t             redirect,
    output exec_pkg::exc_t                  exc,
    output logic [exec_pkg::reg_addr_w-1:0] rs1_addr,
    output logic [exec_pkg::reg_addr_w-1:0] rs2_addr,
    input  logic [exec_pkg::xlen-1:0]       rs1_data,
    input  logic [exec_pkg::xlen-1:0]       rs2_data,
    output exec_pkg::rd_write_t             rd,
    output exec_pkg::mem_req_t              mem_req,
    input  exec_pkg::mem_rsp_t              mem_rsp
);
    import exec_pkg::*;

    decoded_t        dec;
    logic            alu_is_imm;
    logic [xlen-1:0] alu_result;
    logic            alu_illegal;
    logic            br_illegal;
    logic            illegal;
    logic            deferred_illegal;
    logic            start_load;
    logic            start_store;
    logic            mem_busy;
    exc_t            mem_fault;
    logic            load_done;
    logic            wb_en;
    logic [xlen-1:0] wb_data;
    logic [xlen-1:0] pc_plus_4;

    assign rs1_addr   = fetch_in.instr[19:15];
    assign rs2_addr   = fetch_in.instr[24:20];
    assign alu_is_imm = (fetch_in.instr[6:0] == op_imm);
    assign pc_plus_4  = fetch_in.pc + 32'd4;

    exec_decoder u_decoder (
        .instr (fetch_in.instr),
        .dec   (dec)
    );

    exec_alu u_alu (
        .is_imm  (alu_is_imm),
        .funct3  (dec.funct3),
        .funct7  (dec.funct7),
        .rs1     (rs1_data),
        .rs2     (rs2_data),
        .imm     (dec.imm),
        .result  (alu_result),
        .illegal (alu_illegal)
    );

    exec_branch_unit u_branch (
        .dec      (dec),
        .pc       (fetch_in.pc),
        .rs1      (rs1_data),
        .rs2      (rs2_data),
        .redirect (redirect),
        .illegal  (br_illegal)
    );

    assign start_load  = (dec.iclass == cls_load);
    assign start_store = (dec.iclass == cls_store);

    exec_mem_ctrl u_mem_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .start_load  (start_load),
        .start_store (start_store),
        .address     (rs1_data + dec.imm),
        .size        (dec.funct3),
        .store_data  (rs2_data),
        .mem_req     (mem_req),
        .mem_rsp     (mem_rsp),
        .busy        (mem_busy),
        .fault       (mem_fault)
    );

    assign illegal = (dec.iclass == cls_illegal) ||
                     ((dec.iclass == cls_alu) && alu_illegal) || br_illegal;

    // Illegal instruction stalls one cycle, then traps
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            deferred_illegal <= 1'b0;
        end else begin
            deferred_illegal <= illegal && !deferred_illegal;
        end
    end

    always_comb begin
        if (deferred_illegal) begin
            ready = 1'b1;
        end else if (illegal) begin
            ready = 1'b0;
        end else begin
            ready = !mem_busy;
        end
    end

    always_comb begin
        if (deferred_illegal) begin
            exc.start = 1'b1;
            exc.cause = cause_illegal;
        end else begin
            exc = mem_fault;
        end
    end

    // Load result is valid in the response cycle only
    assign load_done = start_load && !mem_busy && !mem_fault.start;

    always_comb begin
        wb_en   = 1'b1;
        wb_data = alu_result;
        case (dec.iclass)
            cls_alu:           wb_data = alu_result;
            cls_jal, cls_jalr: wb_data = pc_plus_4;
            cls_lui:           wb_data = dec.imm;
            cls_auipc:         wb_data = fetch_in.pc + dec.imm;
            cls_load: begin
                wb_en   = load_done;
                wb_data = mem_rsp.load_data;
            end
            default:           wb_en = 1'b0;
        endcase
    end

    // x0 is never written
    assign rd.addr  = dec.rd;
    assign rd.data  = wb_data;
    assign rd.write = wb_en && !illegal && (dec.rd != '0);

endmodule

//--- run.sh
#!/bin/sh
# Build and run the execute stage testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module exec_tb -f files.f -o exec_sim &&
./obj_dir/exec_sim | tee /dev/stderr | grep -q "Done: no errors" &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }
